// File: Makefile
# Verilator build and run of the SPI flash emulator testbench
.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_flash_emu
	./obj_dir/Vtb_flash_emu 2>&1 | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module tb_flash_emu

clean:
	rm -rf obj_dir sim.log

// File: bench/flash_emu_vectors.svh
// test step table with stimulus and expected values for the flash emulator testbench
`ifndef FLASH_EMU_VECTORS_SVH
`define FLASH_EMU_VECTORS_SVH

// traffic generated by one row
typedef enum logic [1:0] {
	STEP_APB_WR,
	STEP_APB_RD,
	STEP_SPI_RD,
	STEP_APB_RD_SPI
} step_kind_t;

// columns are kind, opcode, flash address and length in bytes,
// then the fixed-byte flag, that byte and the APB address of an overlapped read
typedef struct packed {
	step_kind_t kind;
	spi_byte_t  opcode;
	spi_addr_t  addr;
	logic [7:0] len;
	logic       fixed;
	spi_byte_t  exp_byte;
	img_addr_t  apb_addr;
} step_t;

localparam int NUM_STEPS = 9;

step_t steps [NUM_STEPS];

// rows without the fixed flag expect the shadow image bytes
task automatic load_steps();
	steps[0] = '{STEP_APB_WR, 8'h00, 24'h001230, 8'd16, 1'b0, 8'h00, '0};
	// runs past the top of the image into address 0
	steps[1] = '{STEP_APB_WR, 8'h00, 24'h00fff8, 8'd16, 1'b0, 8'h00, '0};
	steps[2] = '{STEP_APB_WR, 8'h00, 24'h000800, 8'd4, 1'b0, 8'h00, '0};
	steps[3] = '{STEP_APB_RD, 8'h00, 24'h001230, 8'd16, 1'b0, 8'h00, '0};
	steps[4] = '{STEP_APB_RD, 8'h00, 24'h00fff8, 8'd16, 1'b0, 8'h00, '0};
	steps[5] = '{STEP_SPI_RD, `FE_OP_READ, 24'h001230, 8'd16, 1'b0, 8'h00, '0};
	// upper address bits dropped
	// so the burst wraps to 0
	steps[6] = '{STEP_SPI_RD, `FE_OP_READ, 24'h5afff8, 8'd16, 1'b0, 8'h00, '0};
	// fast read is not decoded
	steps[7] = '{STEP_SPI_RD, 8'h0b, 24'h001230, 8'd8, 1'b1, 8'hff, '0};
	steps[8] = '{STEP_APB_RD_SPI, `FE_OP_READ, 24'h001238, 8'd8, 1'b0, 8'h00,
		img_addr_t'('h802)};
endtask

`endif

// File: bench/tb_flash_emu.sv
// testbench for the SPI flash emulator with APB and SPI drivers, step table and timeout
`timescale 1ns/100ps
`include "flash_emu_macros.svh"

module tb_flash_emu;
	import spi_pkg::*;
	import mem_pkg::*;

	// spi_clk half period in clk cycles
	localparam int HALF_CLKS = 10;

	logic      clk = 1'b0;
	logic      rst;
	logic      spi_clk;
	logic      spi_cs_n;
	logic      spi_mosi;
	logic      spi_miso;
	logic      psel;
	logic      penable;
	logic      pwrite;
	img_addr_t paddr;
	img_data_t pwdata;
	logic      pready;
	img_data_t prdata;

	`include "flash_emu_vectors.svh"

	// expected image contents
	img_data_t shadow [2**`FE_ADDR_BITS];
	// MISO bytes after the four command bytes
	spi_byte_t rx_q [$];
	// command bytes are out, the reader owns the memory
	logic      cmd_sent = 1'b0;
	integer    seed = 32'h3ea0;
	int        errors = 0;
	int        steps_ok = 0;
	int        steps_bad = 0;
	int        cycles = 0;
	int        cycle_limit = 0;

	flash_emu_top u_dut (.*);

	always #2 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still busy after %0d clk cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [7:0] got,
			input logic [7:0] want);
		if (got !== want) begin
			$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, want);
			errors++;
		end
	endtask

	task automatic finish_step(input string label, input int errs_before);
		if (errors == errs_before) begin
			steps_ok++;
			$display("%s: ok", label);
		end else begin
			steps_bad++;
			$display("%s: %0d mismatches", label, errors - errs_before);
		end
	endtask

	// one APB transfer, setup then access until pready
	task automatic apb_transfer(input logic write, input img_addr_t addr,
			input img_data_t wdata, output img_data_t rdata, output logic cs_n_at_end);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) begin
			@(negedge clk);
		end
		rdata = prdata;
		cs_n_at_end = spi_cs_n;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// mode 0 byte, MSB first
	// MISO taken just before the rising edge, MOSI changes with the fall
	task automatic spi_byte(input spi_byte_t tx, output spi_byte_t rx);
		int i;
		rx = '0;
		for (i = 7; i >= 0; i--) begin
			spi_mosi <= tx[i];
			repeat (HALF_CLKS) @(posedge clk);
			rx[i] = spi_miso;
			spi_clk <= 1'b1;
			repeat (HALF_CLKS) @(posedge clk);
			spi_clk <= 1'b0;
		end
	endtask

	// opcode, 24-bit address, then len data bytes into rx_q
	task automatic spi_burst(input spi_byte_t op, input spi_addr_t addr, input int len);
		spi_byte_t cmd [4];
		spi_byte_t rx;
		int i;
		cmd[0] = op;
		cmd[1] = addr[23:16];
		cmd[2] = addr[15:8];
		cmd[3] = addr[7:0];
		rx_q.delete();
		@(posedge clk);
		spi_cs_n <= 1'b0;
		repeat (HALF_CLKS) @(posedge clk);
		for (i = 0; i < 4; i++) begin
			spi_byte(cmd[i], rx);
		end
		cmd_sent = 1'b1;
		for (i = 0; i < len; i++) begin
			spi_byte(8'h00, rx);
			rx_q.push_back(rx);
		end
		repeat (HALF_CLKS) @(posedge clk);
		spi_cs_n <= 1'b1;
		// synchronised chip select releases the memory
		repeat (2 * HALF_CLKS) @(posedge clk);
		cmd_sent = 1'b0;
	endtask

	task automatic run_step(input int n, input step_t s);
		int        errs_before;
		int        k;
		img_addr_t base;
		img_addr_t a;
		img_data_t wd;
		img_data_t rd;
		logic      cs_n_done;
		errs_before = errors;
		// flash address bits above the image width are ignored
		base = s.addr[`FE_ADDR_BITS-1:0];
		case (s.kind)
			STEP_APB_WR: begin
				for (k = 0; k < int'(s.len); k++) begin
					a = base + img_addr_t'(k);
					wd = img_data_t'($random(seed));
					shadow[a] = wd;
					apb_transfer(1'b1, a, wd, rd, cs_n_done);
				end
			end
			STEP_APB_RD: begin
				for (k = 0; k < int'(s.len); k++) begin
					a = base + img_addr_t'(k);
					apb_transfer(1'b0, a, 8'h00, rd, cs_n_done);
					compare_value("prdata", rd, shadow[a]);
				end
			end
			STEP_SPI_RD: spi_burst(s.opcode, s.addr, int'(s.len));
			default: begin
				fork
					spi_burst(s.opcode, s.addr, int'(s.len));
					begin
						wait (cmd_sent);
						apb_transfer(1'b0, s.apb_addr, 8'h00, rd, cs_n_done);
						// host read may end only after chip select rises
						compare_value("spi_cs_n", {7'd0, cs_n_done}, 8'h01);
						compare_value("prdata", rd, shadow[s.apb_addr]);
					end
				join
			end
		endcase
		if (s.kind == STEP_SPI_RD || s.kind == STEP_APB_RD_SPI) begin
			for (k = 0; k < int'(s.len); k++) begin
				a = base + img_addr_t'(k);
				compare_value("spi_miso", rx_q[k], s.fixed ? s.exp_byte : shadow[a]);
			end
		end
		finish_step($sformatf("step %0d kind %0d addr 0x%06h len %0d", n, s.kind, s.addr,
			s.len), errs_before);
	endtask

	initial begin
		int n;
		rst = 1'b1;
		// chip select starts low, its first rise clears the SPI shifter
		spi_cs_n = 1'b0;
		spi_clk = 1'b0;
		spi_mosi = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		load_steps();
		// 20 clk per bit of every row, plus margin
		cycle_limit = 2000;
		for (n = 0; n < NUM_STEPS; n++) begin
			cycle_limit += int'(steps[n].len) * 8 * 20;
		end
		@(posedge clk);
		spi_cs_n <= 1'b1;
		repeat (9) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_value("spi_miso", {7'd0, spi_miso}, 8'h01);
		compare_value("pready", {7'd0, pready}, 8'h00);
		finish_step("reset state", 0);
		for (n = 0; n < NUM_STEPS; n++) begin
			run_step(n, steps[n]);
		end
		$display("steps passed %0d, failed %0d", steps_ok, steps_bad);
		if (steps_bad == 0 && errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: rtl/flash_emu_macros.svh
// image address width, SPI READ opcode and idle MISO byte
`ifndef FLASH_EMU_MACROS_SVH
`define FLASH_EMU_MACROS_SVH

// image address width in bits
// 16 gives a 64 KB image, anything from 12 to 24 fits the SPI address
`define FE_ADDR_BITS 16

// single-wire READ command
// address bytes follow MSB first, then data for as long as chip select is low
`define FE_OP_READ 8'h03

// byte shifted out when no image data is available
// a released MISO line reads as all ones
`define FE_IDLE_BYTE 8'hFF

`endif

// File: rtl/flash_emu_top.sv
// SPI flash emulator top level with SPI pins, APB port and image memory
`timescale 1ns/100ps
`include "flash_emu_macros.svh"

module flash_emu_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               spi_clk,
	input  logic               spi_cs_n,
	input  logic               spi_mosi,
	output logic               spi_miso,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  mem_pkg::img_addr_t paddr,
	input  mem_pkg::img_data_t pwdata,
	output logic               pready,
	output mem_pkg::img_data_t prdata
);
	import spi_pkg::*;
	import mem_pkg::*;

	// spi_clk domain to the read engine
	spi_byte_t rx_data;
	logic      rx_toggle;
	logic      cmd_toggle;
	// clk domain back to the shifter
	spi_byte_t tx_byte;
	logic      spi_active;
	mem_req_t  spi_req;
	mem_rsp_t  spi_rsp;
	mem_req_t  ram_req;
	mem_rsp_t  ram_rsp;

	spi_device u_spi_device (
		.spi_clk    (spi_clk),
		.spi_cs_n   (spi_cs_n),
		.spi_mosi   (spi_mosi),
		.spi_miso   (spi_miso),
		.tx_byte    (tx_byte),
		.rx_data    (rx_data),
		.rx_toggle  (rx_toggle),
		.cmd_toggle (cmd_toggle)
	);

	spi_read_engine u_read_engine (
		.clk        (clk),
		.rst        (rst),
		.spi_cs_n   (spi_cs_n),
		.rx_data    (rx_data),
		.rx_toggle  (rx_toggle),
		.cmd_toggle (cmd_toggle),
		.tx_byte    (tx_byte),
		.spi_active (spi_active),
		.mem_req    (spi_req),
		.mem_rsp    (spi_rsp)
	);

	image_arbiter u_arbiter (
		.clk        (clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pready     (pready),
		.prdata     (prdata),
		.spi_active (spi_active),
		.spi_req    (spi_req),
		.spi_rsp    (spi_rsp),
		.ram_req    (ram_req),
		.ram_rsp    (ram_rsp)
	);

	image_ram u_ram (
		.clk (clk),
		.req (ram_req),
		.rsp (ram_rsp)
	);

endmodule

// File: rtl/image_arbiter.sv
// APB slave and image memory arbiter between the host and the SPI reader
`timescale 1ns/100ps
`include "flash_emu_macros.svh"

module image_arbiter (
	input  logic               clk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  mem_pkg::img_addr_t paddr,
	input  mem_pkg::img_data_t pwdata,
	output logic               pready,
	output mem_pkg::img_data_t prdata,
	input  logic               spi_active,
	input  mem_pkg::mem_req_t  spi_req,
	output mem_pkg::mem_rsp_t  spi_rsp,
	output mem_pkg::mem_req_t  ram_req,
	input  mem_pkg::mem_rsp_t  ram_rsp
);
	import mem_pkg::*;

	arb_state_t state;
	mem_req_t   apb_req;
	// outstanding read belongs to the SPI reader
	logic       rsp_to_spi;
	logic       apb_rsp_valid;

	// host transfers start only while the SPI reader is idle
	// otherwise the access phase stalls with pready low
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ARB_IDLE;
			rsp_to_spi <= 1'b0;
		end else begin
			rsp_to_spi <= spi_req.valid;
			case (state)
				// after a completion the next setup phase may already be on the bus
				ARB_IDLE, ARB_DONE: begin
					state <= (psel && !spi_active) ? ARB_ACCESS : ARB_IDLE;
				end
				ARB_ACCESS: begin
					state <= pwrite ? ARB_DONE : ARB_WAIT_RSP;
				end
				ARB_WAIT_RSP: begin
					if (apb_rsp_valid) begin
						state <= ARB_DONE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// host request issued in the access phase
	always_comb begin
		apb_req.valid = (state == ARB_ACCESS) && psel && penable;
		apb_req.write = pwrite;
		apb_req.addr = paddr;
		apb_req.wdata = pwdata;
	end

	// SPI reads win whenever they are present
	assign ram_req = spi_req.valid ? spi_req : apb_req;

	// steer the read response to whoever asked
	assign apb_rsp_valid = ram_rsp.valid && !rsp_to_spi;
	assign spi_rsp.valid = ram_rsp.valid && rsp_to_spi;
	assign spi_rsp.rdata = ram_rsp.rdata;

	// writes finish in the access cycle, reads on their response
	assign pready = (apb_req.valid && pwrite) || (state == ARB_WAIT_RSP && apb_rsp_valid);
	assign prdata = ram_rsp.rdata;

endmodule

// File: rtl/image_ram.sv
// synchronous single-port image memory with a one-cycle read response
`timescale 1ns/100ps
`include "flash_emu_macros.svh"

module image_ram (
	input  logic              clk,
	input  mem_pkg::mem_req_t req,
	output mem_pkg::mem_rsp_t rsp
);
	import mem_pkg::*;

	// whole flash image, one byte per address
	img_data_t mem [2**`FE_ADDR_BITS];

	// write port
	always_ff @(posedge clk) begin
		if (req.valid && req.write) begin
			mem[req.addr] <= req.wdata;
		end
	end

	// read port, data and flag both one cycle after the request
	always_ff @(posedge clk) begin
		rsp.rdata <= mem[req.addr];
		rsp.valid <= req.valid && !req.write;
	end

endmodule

// File: rtl/mem_pkg.sv
// memory side types for the image address and data, request, response and arbiter states
`include "flash_emu_macros.svh"

package mem_pkg;

	// byte address into the image
	typedef logic [`FE_ADDR_BITS-1:0] img_addr_t;

	// one image byte
	typedef logic [7:0] img_data_t;

	// single-byte access to the image RAM
	typedef struct packed {
		logic      valid;
		logic      write;
		img_addr_t addr;
		img_data_t wdata;
	} mem_req_t;

	// read data, valid one cycle after the read request
	typedef struct packed {
		logic      valid;
		img_data_t rdata;
	} mem_rsp_t;

	// APB side of the image arbiter
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ACCESS,
		ARB_WAIT_RSP,
		ARB_DONE
	} arb_state_t;

endpackage

// File: rtl/spi_device.sv
// SPI slave shifter in the spi_clk domain with byte and command toggle outputs
`timescale 1ns/100ps
`include "flash_emu_macros.svh"

module spi_device (
	input  logic               spi_clk,
	input  logic               spi_cs_n,
	input  logic               spi_mosi,
	output logic               spi_miso,
	input  spi_pkg::spi_byte_t tx_byte,
	output spi_pkg::spi_byte_t rx_data,
	output logic               rx_toggle,
	output logic               cmd_toggle
);
	import spi_pkg::*;

	// bit position within the current byte
	logic [2:0] bit_cnt;
	// first seven bits of the byte being received
	logic [6:0] rx_shift;
	// still inside the opcode byte
	logic       first_byte;
	// output shifter, MSB drives MISO
	spi_byte_t  tx_shift;

	// toggles keep their level across chip select
	// so the clk side sees exactly one edge per byte
	logic rx_tgl = 1'b0;
	logic cmd_tgl = 1'b0;

	// receive side, mode 0
	// MOSI sampled on the rising edge
	// chip select high clears the bit position
	always_ff @(posedge spi_clk or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			bit_cnt <= 3'd0;
			rx_shift <= '0;
			first_byte <= 1'b1;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			rx_shift <= {rx_shift[5:0], spi_mosi};
			if (bit_cnt == 3'd7) begin
				first_byte <= 1'b0;
			end
		end
	end

	// completed byte and its toggles
	// rx_data then holds for a whole byte period
	always_ff @(posedge spi_clk) begin
		if (!spi_cs_n && bit_cnt == 3'd7) begin
			rx_data <= {rx_shift, spi_mosi};
			rx_tgl <= ~rx_tgl;
			// opcode byte also marks the start of a command
			if (first_byte) begin
				cmd_tgl <= ~cmd_tgl;
			end
		end
	end

	// transmit side
	// reload on the first falling edge after a byte completes
	// otherwise shift left and fill with ones
	always_ff @(negedge spi_clk or posedge spi_cs_n) begin
		if (spi_cs_n) begin
			tx_shift <= `FE_IDLE_BYTE;
		end else if (bit_cnt == 3'd0) begin
			tx_shift <= tx_byte;
		end else begin
			tx_shift <= {tx_shift[6:0], 1'b1};
		end
	end

	// deselected device leaves MISO high
	assign spi_miso = spi_cs_n | tx_shift[7];
	assign rx_toggle = rx_tgl;
	assign cmd_toggle = cmd_tgl;

endmodule

// File: rtl/spi_pkg.sv
// SPI side types for the data byte, the opcode, the flash address and the receive event
package spi_pkg;

	// one byte as shifted on MOSI or MISO
	typedef logic [7:0] spi_byte_t;

	// first byte after chip select falls
	typedef logic [7:0] spi_op_t;

	// full three-byte flash address as sent by the master
	typedef logic [23:0] spi_addr_t;

	// one receive event in the clk domain
	// strobe lasts a single clk cycle per byte
	typedef struct packed {
		// a new byte has arrived
		logic      strobe;
		// byte is the opcode of a new command
		logic      first;
		// received byte
		spi_byte_t data;
	} spi_rx_evt_t;

endpackage

// File: rtl/spi_read_engine.sv
// clk-domain synchronisers, SPI command and address decoder and burst read FSM
`timescale 1ns/100ps
`include "flash_emu_macros.svh"

module spi_read_engine (
	input  logic               clk,
	input  logic               rst,
	input  logic               spi_cs_n,
	input  spi_pkg::spi_byte_t rx_data,
	input  logic               rx_toggle,
	input  logic               cmd_toggle,
	output spi_pkg::spi_byte_t tx_byte,
	output logic               spi_active,
	output mem_pkg::mem_req_t  mem_req,
	input  mem_pkg::mem_rsp_t  mem_rsp
);
	import spi_pkg::*;
	import mem_pkg::*;

	// opcode, address bytes, data burst, ignored command
	typedef enum logic [1:0] {
		SE_IDLE,
		SE_ADDR,
		SE_BURST,
		SE_SKIP
	} se_state_t;

	// two sync flops plus one for edge detection on each toggle
	logic [2:0]  rx_sync;
	logic [2:0]  cmd_sync;
	logic [1:0]  cs_sync;
	logic        cs_high;
	spi_rx_evt_t rx_evt;

	se_state_t   state;
	logic [1:0]  addr_cnt;
	spi_op_t     opcode;
	spi_byte_t   addr_hi;
	spi_byte_t   addr_mid;
	spi_addr_t   full_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_sync <= '0;
			cmd_sync <= '0;
			cs_sync <= 2'b11;
			rx_evt <= '0;
		end else begin
			rx_sync <= {rx_sync[1:0], rx_toggle};
			cmd_sync <= {cmd_sync[1:0], cmd_toggle};
			cs_sync <= {cs_sync[0], spi_cs_n};
			// registered event
			// strobe lands 3 clk after the spi_clk edge
			rx_evt.strobe <= rx_sync[2] ^ rx_sync[1];
			rx_evt.first <= cmd_sync[2] ^ cmd_sync[1];
			rx_evt.data <= rx_data;
		end
	end

	assign cs_high = cs_sync[1];

	// address bytes arrive MSB first
	// the last one is taken straight from the event
	assign full_addr = {addr_hi, addr_mid, rx_evt.data};

	// opcode and upper address bytes
	always_ff @(posedge clk) begin
		if (rx_evt.strobe && rx_evt.first) begin
			opcode <= rx_evt.data;
		end else if (rx_evt.strobe && state == SE_ADDR) begin
			addr_hi <= addr_mid;
			addr_mid <= rx_evt.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SE_IDLE;
			addr_cnt <= 2'd0;
			spi_active <= 1'b0;
			tx_byte <= `FE_IDLE_BYTE;
			mem_req <= '0;
		end else begin
			// requests last one cycle
			mem_req.valid <= 1'b0;
			// image byte for the next falling-edge reload
			if (mem_rsp.valid) begin
				tx_byte <= mem_rsp.rdata;
			end
			if (rx_evt.strobe && rx_evt.first) begin
				// new command takes the memory over
				state <= SE_ADDR;
				addr_cnt <= 2'd0;
				spi_active <= 1'b1;
				tx_byte <= `FE_IDLE_BYTE;
			end else if (rx_evt.strobe) begin
				case (state)
					SE_ADDR: begin
						addr_cnt <= addr_cnt + 2'd1;
						// fourth byte completes the address
						if (addr_cnt == 2'd2) begin
							if (opcode == `FE_OP_READ) begin
								mem_req.valid <= 1'b1;
								mem_req.addr <= full_addr[`FE_ADDR_BITS-1:0];
								state <= SE_BURST;
							end else begin
								state <= SE_SKIP;
							end
						end
					end
					// each clocked-out byte fetches the next one
					// and the address wraps at the image size
					SE_BURST: begin
						mem_req.valid <= 1'b1;
						mem_req.addr <= mem_req.addr + img_addr_t'(1);
					end
					default: begin
						state <= state;
					end
				endcase
			end else if (cs_high) begin
				// chip select released
				state <= SE_IDLE;
				spi_active <= 1'b0;
				tx_byte <= `FE_IDLE_BYTE;
			end
		end
	end

endmodule

// File: vlog.f
+incdir+rtl
+incdir+bench
rtl/spi_pkg.sv
rtl/mem_pkg.sv
rtl/spi_device.sv
rtl/spi_read_engine.sv
rtl/image_arbiter.sv
rtl/image_ram.sv
rtl/flash_emu_top.sv
bench/tb_flash_emu.sv
